//--- hdl/data_io_pkg.sv
// loader bridge shared types, spi command codes and the acknowledge byte
`default_nettype none

package data_io_pkg;

    // **************************************************
    // vector types
    // **************************************************

    // one byte as shifted over the spi bus
    typedef logic [7:0] spi_byte_t;

    // menu slot of the uploaded file
    typedef logic [4:0] menu_index_t;

    // bit position within a frame
    // 0..7 is the command byte, then 8..15 repeats per payload byte
    typedef logic [4:0] bit_cnt_t;

    // payload byte number within a frame, saturates at 255
    typedef logic [7:0] byte_cnt_t;

    // **************************************************
    // command codes, first byte of every frame
    // **************************************************

    localparam spi_byte_t cmd_ack      = 8'h00;  // reply with ack_byte
    localparam spi_byte_t cmd_status   = 8'h10;  // reply with external status
    localparam spi_byte_t cmd_conf_str = 8'h14;  // stream out config string
    localparam spi_byte_t cmd_index    = 8'h55;  // latch the menu index
    localparam spi_byte_t cmd_pump     = 8'h61;  // start or continue a download
    localparam spi_byte_t cmd_pump_end = 8'h62;  // end of download

    // letter K, answer to cmd_ack
    localparam spi_byte_t ack_byte     = 8'h4b;

endpackage

`default_nettype wire

//--- hdl/spi_cmd_rx.sv
// spi command receiver, shifts in frames on sck and decodes command and payload bytes
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_rx (
    input  wire                          rst,
    input  wire                          ss,
    input  wire                          sck,
    input  wire                          sdi,
    output data_io_pkg::spi_byte_t       cmd,
    output data_io_pkg::bit_cnt_t        bit_cnt,
    output data_io_pkg::byte_cnt_t       byte_cnt,
    output logic                         download_flag,
    output data_io_pkg::spi_byte_t       pump_data,
    output logic                         pump_toggle,
    output data_io_pkg::menu_index_t     index
);

    // idle command while deselected, matches no code so no reply is given
    localparam data_io_pkg::spi_byte_t no_cmd = 8'hff;

    // first seven bits of the byte in flight
    logic [6:0]             sbuf;
    // full byte, last bit taken straight from the pin
    data_io_pkg::spi_byte_t rx_byte;

    assign rx_byte = {sbuf, sdi};

    // **************************************************
    // shift register and frame counters
    // **************************************************

    always_ff @(posedge sck)
    begin
        sbuf <= {sbuf[5:0], sdi};
        // pumped byte is held until the next one arrives
        if (bit_cnt == 5'd15 && cmd == data_io_pkg::cmd_pump)
        begin
            pump_data <= rx_byte;
        end
    end

    // ss high ends the frame and clears the counters
    always_ff @(posedge sck or posedge ss or posedge rst)
    begin
        if (rst || ss)
        begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            cmd      <= no_cmd;
        end
        else
        begin
            // count 0..15, then loop over 8..15 for each payload byte
            if (bit_cnt < 5'd15)
            begin
                bit_cnt <= bit_cnt + 5'd1;
            end
            else
            begin
                bit_cnt <= 5'd8;
            end

            // payload byte done, stop at 255
            if (bit_cnt == 5'd15 && byte_cnt != 8'hff)
            begin
                byte_cnt <= byte_cnt + 8'd1;
            end

            // command is valid from the eighth rising edge on
            if (bit_cnt == 5'd7)
            begin
                cmd <= rx_byte;
            end
        end
    end

    // **************************************************
    // command decode
    // **************************************************

    // download level survives across frames, only commands or rst change it
    always_ff @(posedge sck or posedge rst)
    begin
        if (rst)
        begin
            download_flag <= 1'b0;
        end
        else if (bit_cnt == 5'd7)
        begin
            if (rx_byte == data_io_pkg::cmd_pump)
            begin
                download_flag <= 1'b1;
            end
            else if (rx_byte == data_io_pkg::cmd_pump_end)
            begin
                download_flag <= 1'b0;
            end
        end
    end

    // toggle strobe per pumped byte and menu index
    always_ff @(posedge sck or posedge rst)
    begin
        if (rst)
        begin
            pump_toggle <= 1'b0;
            index       <= '0;
        end
        else if (bit_cnt == 5'd15)
        begin
            if (cmd == data_io_pkg::cmd_pump)
            begin
                pump_toggle <= ~pump_toggle;
            end
            // only the first payload byte carries the index
            if (cmd == data_io_pkg::cmd_index && byte_cnt == 8'd0)
            begin
                index <= rx_byte[4:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/spi_reply_tx.sv
// spi reply shifter, drives sdo on the falling sck edge from the selected reply source
`timescale 1ns/1ps
`default_nettype none

module spi_reply_tx #(
    parameter int str_len = 0
) (
    input  wire                            rst,
    input  wire                            ss,
    input  wire                            sck,
    input  wire data_io_pkg::spi_byte_t    cmd,
    input  wire data_io_pkg::bit_cnt_t     bit_cnt,
    input  wire data_io_pkg::byte_cnt_t    byte_cnt,
    input  wire data_io_pkg::spi_byte_t    pump_data,
    input  wire data_io_pkg::spi_byte_t    data_in,
    input  wire [8*str_len-1:0]            conf_str,
    output logic                           sdo
);

    // bit of the byte that the master samples next, msb first
    logic [2:0] bit_idx;
    // current bit of the configuration string
    logic       conf_bit;

    // bit_cnt already points at the next position after the rising edge
    assign bit_idx = ~bit_cnt[2:0];

    // **************************************************
    // configuration string character select
    // **************************************************

    generate
        if (str_len == 0)
        begin : g_no_str
            // nothing to send, zero bytes only
            assign conf_bit = 1'b0;
        end
        else
        begin : g_str
            data_io_pkg::spi_byte_t conf_char;

            always_comb
            begin
                int char_pos;
                // character 0 sits in the top byte of conf_str
                char_pos  = str_len - 1 - int'(byte_cnt);
                conf_char = '0;
                if (int'(byte_cnt) < str_len)
                begin
                    conf_char = conf_str[8*char_pos +: 8];
                end
            end

            assign conf_bit = conf_char[bit_idx];
        end
    endgenerate

    // **************************************************
    // reply shifter
    // **************************************************

    // deselected slave drives low, no tri-state here
    always_ff @(negedge sck or posedge ss or posedge rst)
    begin
        if (rst || ss)
        begin
            sdo <= 1'b0;
        end
        else
        begin
            case (cmd)
                data_io_pkg::cmd_ack:      sdo <= data_io_pkg::ack_byte[bit_idx];
                // status is picked up bit by bit as it goes out
                data_io_pkg::cmd_status:   sdo <= data_in[bit_idx];
                // echo of the byte pumped in the previous payload slot
                data_io_pkg::cmd_pump:     sdo <= pump_data[bit_idx];
                data_io_pkg::cmd_conf_str: sdo <= conf_bit;
                // idle 0xff during the command byte lands here too
                default:                   sdo <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/ioctl_writer.sv
// memory write port in the clk_sdram domain, turns pumped spi bytes into byte writes
`timescale 1ns/1ps
`default_nettype none

module ioctl_writer #(
    parameter int addr_width = 22
) (
    input  wire                            clk_sdram,
    input  wire                            rst,
    input  wire                            download_flag,
    input  wire                            pump_toggle,
    input  wire data_io_pkg::spi_byte_t    pump_data,
    output logic                           downloading,
    output logic [addr_width-1:0]          ioctl_addr,
    output data_io_pkg::spi_byte_t         ioctl_data,
    output logic                           ioctl_wr
);

    // first stage of the download level synchronizer
    logic       dl_meta;
    // pump toggle through three flops, [0] is the metastable one
    logic [2:0] tog_sync;
    // new byte seen in the sdram domain
    logic       new_byte;
    // download starts in this cycle
    logic       dl_start;

    assign new_byte = tog_sync[2] ^ tog_sync[1];
    assign dl_start = dl_meta & ~downloading;

    // **************************************************
    // synchronizers
    // **************************************************

    always_ff @(posedge clk_sdram or posedge rst)
    begin
        if (rst)
        begin
            dl_meta     <= 1'b0;
            downloading <= 1'b0;
            tog_sync    <= '0;
        end
        else
        begin
            dl_meta     <= download_flag;
            downloading <= dl_meta;
            tog_sync    <= {tog_sync[1:0], pump_toggle};
        end
    end

    // **************************************************
    // address counter and write strobe
    // **************************************************

    always_ff @(posedge clk_sdram or posedge rst)
    begin
        if (rst)
        begin
            ioctl_addr <= '1;
            ioctl_data <= '0;
            ioctl_wr   <= 1'b0;
        end
        else
        begin
            // one cycle strobe per toggle edge
            ioctl_wr <= new_byte;

            // all ones so the first increment lands on address 0
            if (dl_start)
            begin
                ioctl_addr <= '1;
            end

            // pump_data is stable long before the toggle gets here
            if (new_byte)
            begin
                ioctl_data <= pump_data;
                ioctl_addr <= ioctl_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/data_io.sv
// loader bridge top, spi command and reply path plus the sdram side byte writer
`timescale 1ns/1ps
`default_nettype none

module data_io #(
    parameter int addr_width = 22,
    parameter int str_len    = 0
) (
    input  wire                              rst,
    input  wire                              clk_sdram,
    // io controller spi, mode 0
    input  wire                              sck,
    input  wire                              ss,
    input  wire                              sdi,
    output wire                              sdo,
    // status byte and configuration string for the controller
    input  wire data_io_pkg::spi_byte_t      data_in,
    input  wire [8*str_len-1:0]              conf_str,
    output wire data_io_pkg::menu_index_t    index,
    // byte wide memory write port
    output wire                              downloading,
    output wire [addr_width-1:0]             ioctl_addr,
    output wire data_io_pkg::spi_byte_t      ioctl_data,
    output wire                              ioctl_wr
);

    // sck domain links
    data_io_pkg::spi_byte_t  cmd;
    data_io_pkg::bit_cnt_t   bit_cnt;
    data_io_pkg::byte_cnt_t  byte_cnt;
    data_io_pkg::spi_byte_t  pump_data;
    // crosses into clk_sdram
    logic                    download_flag;
    logic                    pump_toggle;

    spi_cmd_rx u_cmd_rx (
        .rst           (rst),
        .ss            (ss),
        .sck           (sck),
        .sdi           (sdi),
        .cmd           (cmd),
        .bit_cnt       (bit_cnt),
        .byte_cnt      (byte_cnt),
        .download_flag (download_flag),
        .pump_data     (pump_data),
        .pump_toggle   (pump_toggle),
        .index         (index)
    );

    spi_reply_tx #(
        .str_len (str_len)
    ) u_reply_tx (
        .rst       (rst),
        .ss        (ss),
        .sck       (sck),
        .cmd       (cmd),
        .bit_cnt   (bit_cnt),
        .byte_cnt  (byte_cnt),
        .pump_data (pump_data),
        .data_in   (data_in),
        .conf_str  (conf_str),
        .sdo       (sdo)
    );

    ioctl_writer #(
        .addr_width (addr_width)
    ) u_writer (
        .clk_sdram     (clk_sdram),
        .rst           (rst),
        .download_flag (download_flag),
        .pump_toggle   (pump_toggle),
        .pump_data     (pump_data),
        .downloading   (downloading),
        .ioctl_addr    (ioctl_addr),
        .ioctl_data    (ioctl_data),
        .ioctl_wr      (ioctl_wr)
    );

endmodule

`default_nettype wire

//--- include/tb_spi_master.svh
// spi mode 0 master tasks and galois lfsr for the loader bridge testbench
`ifndef TB_SPI_MASTER_SVH
`define TB_SPI_MASTER_SVH

// **************************************************
// galois lfsr, x^32 + x^22 + x^2 + x + 1
// **************************************************

// one step, one random bit
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
    begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

// eight steps, lsb of each step collected msb first
function automatic logic [7:0] lfsr_byte(inout logic [31:0] state);
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < 8; i++)
    begin
        val   = {val[6:0], state[0]};
        state = lfsr_step(state);
    end
    return val;
endfunction

// **************************************************
// spi master, 800 ns per bit against 100 ns clk_sdram
// **************************************************

// sck falls at the start of each bit, rises four clocks later
task automatic spi_byte(input logic [7:0] tx, input logic [7:0] din, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i >= 0; i--)
    begin
        @(posedge clk_sdram);
        #1;
        // status value set before the falling edge that samples it
        data_in = din;
        sck     = 1'b0;
        sdi     = tx[i];
        repeat (4) @(posedge clk_sdram);
        #1;
        sck   = 1'b1;
        rx[i] = sdo;
        repeat (3) @(posedge clk_sdram);
    end
endtask

// one frame, command byte then payload, reply bytes come back in rx
task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] tx[$],
                         input logic [7:0] din[$], output logic [7:0] rx[$]);
    logic [7:0] cmd_reply;
    logic [7:0] rbyte;
    rx = {};
    @(posedge clk_sdram);
    #1;
    ss = 1'b0;
    spi_byte(cmd, 8'h00, cmd_reply);
    foreach (tx[k])
    begin
        spi_byte(tx[k], (k < din.size()) ? din[k] : 8'h00, rbyte);
        rx.push_back(rbyte);
    end
    @(posedge clk_sdram);
    #1;
    sck = 1'b0;
    repeat (2) @(posedge clk_sdram);
    #1;
    ss = 1'b1;
endtask

`endif

//--- tb/tb_data_io.sv
// loader bridge testbench, runs a table of spi frames and checks replies, index and memory writes
`timescale 1ns/1ps
`default_nettype none

module tb_data_io;

    localparam int addr_width = 22;
    localparam int str_len    = 7;
    localparam int n_rows     = 8;
    localparam int max_pay    = 9;

    // reply markers, bit 8 set means the value is derived at run time
    localparam logic [8:0] rx_any  = 9'h1ff;
    localparam logic [8:0] rx_din  = 9'h100;
    localparam logic [8:0] rx_echo = 9'h101;

    logic                    clk_sdram;
    logic                    rst;
    logic                    sck;
    logic                    ss;
    logic                    sdi;
    logic [7:0]              data_in;
    logic [8*str_len-1:0]    conf_str;
    wire                     sdo;
    wire  [4:0]              index;
    wire                     downloading;
    wire  [addr_width-1:0]   ioctl_addr;
    wire  [7:0]              ioctl_data;
    wire                     ioctl_wr;

    // stimulus table, one row per frame
    logic [7:0]  tab_cmd     [n_rows];
    int          tab_len     [n_rows];
    logic        tab_rand    [n_rows];
    logic [8:0]  tab_reply   [n_rows][max_pay];
    int          tab_wr_base [n_rows];
    logic        tab_index   [n_rows];

    logic [31:0]           lfsr_state;
    logic [addr_width-1:0] exp_addr[$];
    logic [7:0]            exp_data[$];
    int                    errors;
    int                    writes_seen;

    `include "tb_spi_master.svh"

    data_io #(
        .addr_width (addr_width),
        .str_len    (str_len)
    ) dut0 (
        .rst         (rst),
        .clk_sdram   (clk_sdram),
        .sck         (sck),
        .ss          (ss),
        .sdi         (sdi),
        .sdo         (sdo),
        .data_in     (data_in),
        .conf_str    (conf_str),
        .index       (index),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr)
    );

    // 100 ns clk_sdram
    always #50 clk_sdram = ~clk_sdram;

    // **************************************************
    // table contents
    // **************************************************

    // scalar fields of one row, a negative write base means no writes
    task automatic set_row(input int r, input logic [7:0] cmd, input int len,
                           input logic rnd, input int wr_base, input logic idx);
        tab_cmd[r]     = cmd;
        tab_len[r]     = len;
        tab_rand[r]    = rnd;
        tab_wr_base[r] = wr_base;
        tab_index[r]   = idx;
    endtask

    task automatic load_table();
        // ack query, three K replies
        set_row(0, 8'h00, 3, 1'b0, -1, 1'b0);
        tab_reply[0] = '{9'h04b, 9'h04b, 9'h04b, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any};
        // config string LOADROM, then two zero bytes past the end
        set_row(1, 8'h14, 9, 1'b0, -1, 1'b0);
        tab_reply[1] = '{9'h04c, 9'h04f, 9'h041, 9'h044, 9'h052, 9'h04f, 9'h04d, 9'h000, 9'h000};
        // status, each reply byte is the data_in held during it
        set_row(2, 8'h10, 4, 1'b0, -1, 1'b0);
        tab_reply[2] = '{rx_din, rx_din, rx_din, rx_din, rx_any, rx_any, rx_any, rx_any, rx_any};
        // menu index from a random byte, no reply
        set_row(3, 8'h55, 1, 1'b1, -1, 1'b1);
        tab_reply[3] = '{9'h000, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any};
        // download of eight bytes, echo from byte 1 on
        set_row(4, 8'h61, 8, 1'b1, 0, 1'b0);
        tab_reply[4] = '{rx_any, rx_echo, rx_echo, rx_echo, rx_echo, rx_echo, rx_echo, rx_echo,
                         rx_any};
        set_row(5, 8'h62, 0, 1'b0, -1, 1'b0);
        tab_reply[5] = '{rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any};
        // second download restarts at address 0
        set_row(6, 8'h61, 3, 1'b1, 0, 1'b0);
        tab_reply[6] = '{rx_any, rx_echo, rx_echo, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any};
        set_row(7, 8'h62, 0, 1'b0, -1, 1'b0);
        tab_reply[7] = '{rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any, rx_any};
    endtask

    // **************************************************
    // one table row
    // **************************************************

    task automatic apply_row(input int r);
        logic [7:0] pay[$];
        logic [7:0] din[$];
        logic [7:0] rx[$];
        logic [7:0] b;
        logic [7:0] exp;
        logic [8:0] mark;
        int         k;
        int         waited;
        pay = {};
        din = {};
        for (k = 0; k < tab_len[r]; k++)
        begin
            if (tab_rand[r])
            begin
                b = lfsr_byte(lfsr_state);
            end
            else
            begin
                b = 8'h00;
            end
            pay.push_back(b);
            // status value for this byte
            b = lfsr_byte(lfsr_state);
            din.push_back(b);
            if (tab_wr_base[r] >= 0)
            begin
                exp_addr.push_back(addr_width'(tab_wr_base[r] + k));
                exp_data.push_back(pay[k]);
            end
        end

        spi_frame(tab_cmd[r], pay, din, rx);

        for (k = 0; k < tab_len[r]; k++)
        begin
            mark = tab_reply[r][k];
            if (mark == rx_din)
                exp = din[k];
            else if (mark == rx_echo)
                exp = pay[k-1];
            else
                exp = mark[7:0];
            if (mark != rx_any && rx[k] !== exp)
            begin
                $display("FAIL %0t: cmd %02h reply byte %0d is %02h, expected %02h",
                         $time, tab_cmd[r], k, rx[k], exp);
                errors++;
            end
        end

        // flag has had a whole frame to cross over
        if (tab_cmd[r] == 8'h61 && downloading !== 1'b1)
        begin
            $display("FAIL %0t: downloading low after cmd 61", $time);
            errors++;
        end

        if (tab_index[r])
        begin
            repeat (10) @(posedge clk_sdram);
            #1;
            if (index !== pay[0][4:0])
            begin
                $display("FAIL %0t: index is %02h, expected %02h", $time, index, pay[0][4:0]);
                errors++;
            end
        end

        if (tab_cmd[r] == 8'h62)
        begin
            waited = 0;
            while (downloading !== 1'b0 && waited < 10)
            begin
                @(posedge clk_sdram);
                #1;
                waited++;
            end
            if (downloading !== 1'b0)
            begin
                $display("FAIL %0t: downloading still high 10 cycles after cmd 62", $time);
                errors++;
            end
        end

        // last write lands a few clk_sdram cycles after the frame
        waited = 0;
        while (exp_addr.size() != 0 && waited < 12)
        begin
            @(posedge clk_sdram);
            #1;
            waited++;
        end
        if (exp_addr.size() != 0)
        begin
            $display("%0d memory writes never arrived after cmd %02h, at %0t",
                     exp_addr.size(), tab_cmd[r], $time);
            errors++;
            exp_addr = {};
            exp_data = {};
        end
        repeat (4) @(posedge clk_sdram);
    endtask

    // write port monitor, sampled away from the active edge
    always @(negedge clk_sdram)
    begin
        if (ioctl_wr === 1'b1)
        begin
            writes_seen++;
            if (exp_addr.size() == 0)
            begin
                $display("unexpected memory write at %0t, addr %0h data %02h",
                         $time, ioctl_addr, ioctl_data);
                errors++;
            end
            else
            begin
                if (ioctl_addr !== exp_addr[0] || ioctl_data !== exp_data[0])
                begin
                    $display("FAIL %0t: write %0h/%02h, expected %0h/%02h", $time,
                             ioctl_addr, ioctl_data, exp_addr[0], exp_data[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    // **************************************************
    // main sequence
    // **************************************************

    initial
    begin
        int r;
        clk_sdram   = 1'b0;
        rst         = 1'b1;
        sck         = 1'b0;
        ss          = 1'b1;
        sdi         = 1'b0;
        data_in     = 8'h00;
        conf_str    = "LOADROM";
        errors      = 0;
        writes_seen = 0;
        lfsr_state  = 32'hd71;
        load_table();

        repeat (3) @(posedge clk_sdram);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk_sdram);
        #1;

        // idle state before the first frame
        if (ioctl_wr !== 1'b0 || downloading !== 1'b0 || ioctl_addr !== '1)
        begin
            $display("FAIL %0t: after reset wr %b downloading %b addr %0h",
                     $time, ioctl_wr, downloading, ioctl_addr);
            errors++;
        end
        if (ioctl_data !== 8'h00 || index !== 5'h00)
        begin
            $display("FAIL %0t: after reset data %02h index %02h", $time, ioctl_data, index);
            errors++;
        end

        for (r = 0; r < n_rows; r++)
        begin
            apply_row(r);
        end

        $display("errors: %0d, memory writes seen: %0d", errors, writes_seen);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, scaled by the bits in the table plus per frame slack
    initial
    begin
        longint limit_ns;
        int     r;
        #1;
        limit_ns = 20000;
        for (r = 0; r < n_rows; r++)
        begin
            limit_ns = limit_ns + longint'((1 + tab_len[r]) * 8) * 800 + 5000;
        end
        #(limit_ns);
        $display("watchdog expired at %0t, the simulation hung", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hdl/data_io_pkg.sv
hdl/spi_cmd_rx.sv
hdl/spi_reply_tx.sv
hdl/ioctl_writer.sv
hdl/data_io.sv
tb/tb_data_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the loader bridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    -Wno-fatal \
    --top-module tb_data_io \
    -f vlog.f \
    -o tb_data_io

sim_out=$(./obj_dir/tb_data_io)
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
